/* rtl/tinker_pkg.sv */
`default_nettype none

package tinker_pkg;

    // datapath and encoding widths
    localparam int xlen       = 64;
    localparam int ilen       = 32;
    localparam int reg_addr_w = 5;
    localparam int lit_w      = 12;
    // 16 KiB byte-addressed memory
    localparam int mem_addr_w = 14;
    localparam int mem_bytes  = 2 ** mem_addr_w;

    typedef logic [4:0]            opcode_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;
    typedef logic [xlen-1:0]       word_t;
    typedef logic [mem_addr_w-1:0] mem_addr_t;

    // first fetch address after start
    localparam mem_addr_t reset_pc = 14'h2000;

    // integer arithmetic
    localparam opcode_t op_add   = 5'h18;
    localparam opcode_t op_addi  = 5'h19;
    localparam opcode_t op_sub   = 5'h1a;
    localparam opcode_t op_subi  = 5'h1b;
    // logic and shifts, opcode 0 doubles as the bubble encoding
    localparam opcode_t op_and   = 5'h00;
    localparam opcode_t op_or    = 5'h01;
    localparam opcode_t op_xor   = 5'h02;
    localparam opcode_t op_not   = 5'h03;
    localparam opcode_t op_shr   = 5'h04;
    localparam opcode_t op_shri  = 5'h05;
    localparam opcode_t op_shl   = 5'h06;
    localparam opcode_t op_shli  = 5'h07;
    // control flow
    localparam opcode_t op_br    = 5'h08;
    localparam opcode_t op_brr   = 5'h09;
    localparam opcode_t op_brrl  = 5'h0a;
    localparam opcode_t op_brnz  = 5'h0b;
    localparam opcode_t op_brgt  = 5'h0e;
    localparam opcode_t op_halt  = 5'h0f;
    // data movement
    localparam opcode_t op_load  = 5'h10;
    localparam opcode_t op_mov   = 5'h11;
    localparam opcode_t op_movl  = 5'h12;
    localparam opcode_t op_store = 5'h13;

    // ID/EX payload
    typedef struct packed {
        opcode_t   opcode;
        reg_idx_t  rd;
        reg_idx_t  rs;
        reg_idx_t  rt;
        word_t     lit;
        word_t     rs_val;
        word_t     rt_val;
        word_t     rd_val;
        mem_addr_t pc;
        logic      uses_rs;
        logic      uses_rt;
        logic      uses_rd;
        logic      lit_sel;
    } decoded_t;

    // EX/MEM payload
    typedef struct packed {
        reg_idx_t  rd;
        logic      reg_write;
        logic      is_load;
        logic      mem_write;
        logic      halt;
        mem_addr_t mem_addr;
        word_t     store_data;
        word_t     alu_result;
        logic      redirect;
        word_t     target;
    } ex_result_t;

    // MEM/WB payload
    typedef struct packed {
        reg_idx_t rd;
        logic     reg_write;
        logic     halt;
        word_t    data;
    } wb_t;

    // program load strobe, addr counts 32-bit words
    typedef struct packed {
        logic            valid;
        mem_addr_t       addr;
        logic [ilen-1:0] data;
    } load_req_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } retire_t;

    // one forwarding source
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    value;
    } fwd_t;

endpackage

`default_nettype wire

/* rtl/stage_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire      clk,
    input  wire      reset,
    input  wire      flush,
    input  wire      hold,
    input  wire      in_valid,
    input  payload_t in_payload,
    output logic     out_valid,
    output payload_t out_payload
);

    // flush wins over hold
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (!hold) begin
            out_valid <= in_valid;
        end
    end

    // payload only meaningful with out_valid
    always_ff @(posedge clk) begin
        if (!hold) begin
            out_payload <= in_payload;
        end
    end

endmodule

`default_nettype wire

/* rtl/register_file.sv */
`timescale 1ns/10ps
`default_nettype none

module register_file import tinker_pkg::*; (
    input  wire      clk,
    input  wire      reset,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  reg_idx_t rd_idx,
    input  fwd_t     write,
    output word_t    rs_val,
    output word_t    rt_val,
    output word_t    rd_val
);

    word_t regs [2**reg_addr_w];

    // r0 is an ordinary register here
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (write.valid) begin
            regs[write.rd] <= write.value;
        end
    end

    // same-cycle write passes straight through to decode
    always_comb begin
        rs_val = (write.valid && write.rd == rs_idx) ? write.value : regs[rs_idx];
        rt_val = (write.valid && write.rd == rt_idx) ? write.value : regs[rt_idx];
        rd_val = (write.valid && write.rd == rd_idx) ? write.value : regs[rd_idx];
    end

endmodule

`default_nettype wire

/* rtl/data_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module data_memory import tinker_pkg::*; (
    input  wire             clk,
    input  mem_addr_t       fetch_addr,
    input  mem_addr_t       data_addr,
    input  wire             store_en,
    input  word_t           store_data,
    input  load_req_t       load,
    output logic [ilen-1:0] instr,
    output word_t           load_data
);

    logic [7:0] mem [mem_bytes];
    mem_addr_t  load_base;

    // word index to byte address
    assign load_base = {load.addr[mem_addr_w-3:0], 2'b00};

    // little-endian reads, addresses wrap at the top
    always_comb begin
        for (int i = 0; i < ilen / 8; i++) begin
            instr[8*i +: 8] = mem[fetch_addr + mem_addr_t'(i)];
        end
        for (int i = 0; i < xlen / 8; i++) begin
            load_data[8*i +: 8] = mem[data_addr + mem_addr_t'(i)];
        end
    end

    always_ff @(posedge clk) begin
        if (store_en) begin
            for (int i = 0; i < xlen / 8; i++) begin
                mem[data_addr + mem_addr_t'(i)] <= store_data[8*i +: 8];
            end
        end
        // program load only while idle, so never together with a store
        if (load.valid) begin
            for (int i = 0; i < ilen / 8; i++) begin
                mem[load_base + mem_addr_t'(i)] <= load.data[8*i +: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_decode import tinker_pkg::*; (
    input  wire             clk,
    input  wire             reset,
    input  wire             start,
    input  wire [ilen-1:0]  instr,
    input  word_t           rs_val,
    input  word_t           rt_val,
    input  word_t           rd_val,
    input  reg_idx_t        ex_rd,
    input  wire             ex_is_load,
    input  wire             redirect,
    input  word_t           redirect_pc,
    output mem_addr_t       fetch_pc,
    output reg_idx_t        rs_idx,
    output reg_idx_t        rt_idx,
    output reg_idx_t        rd_idx,
    output decoded_t        decoded,
    output logic            decoded_valid,
    output logic            flush_ex
);

    logic            run;
    mem_addr_t       pc;
    logic            ifid_valid;
    logic [ilen-1:0] ifid_instr;
    mem_addr_t       ifid_pc;
    opcode_t         opcode;
    logic            stall;
    logic            halt_dec;

    // field split: op 31:27, rd 26:22, rs 21:17, rt 16:12, lit 11:0
    assign opcode   = ifid_instr[31:27];
    assign rd_idx   = ifid_instr[26:22];
    assign rs_idx   = ifid_instr[21:17];
    assign rt_idx   = ifid_instr[16:12];
    assign fetch_pc = pc;

    always_comb begin
        decoded        = '0;
        decoded.opcode = opcode;
        decoded.rd     = rd_idx;
        decoded.rs     = rs_idx;
        decoded.rt     = rt_idx;
        decoded.lit    = {{(xlen-lit_w){ifid_instr[lit_w-1]}}, ifid_instr[lit_w-1:0]};
        decoded.rs_val = rs_val;
        decoded.rt_val = rt_val;
        decoded.rd_val = rd_val;
        decoded.pc     = ifid_pc;
        // which register fields are real sources
        case (opcode)
            op_add, op_sub, op_and, op_or, op_xor, op_shr, op_shl: begin
                decoded.uses_rs = 1'b1;
                decoded.uses_rt = 1'b1;
            end
            op_not, op_mov: decoded.uses_rs = 1'b1;
            // literal forms operate on rd in place
            op_addi, op_subi, op_shri, op_shli, op_movl: begin
                decoded.uses_rd = 1'b1;
                decoded.lit_sel = 1'b1;
            end
            op_load: begin
                decoded.uses_rs = 1'b1;
                decoded.lit_sel = 1'b1;
            end
            // store: address from rd, data from rs
            op_store: begin
                decoded.uses_rs = 1'b1;
                decoded.uses_rd = 1'b1;
                decoded.lit_sel = 1'b1;
            end
            op_br, op_brr: decoded.uses_rd = 1'b1;
            op_brrl: decoded.lit_sel = 1'b1;
            op_brnz: begin
                decoded.uses_rs = 1'b1;
                decoded.uses_rd = 1'b1;
            end
            op_brgt: begin
                decoded.uses_rs = 1'b1;
                decoded.uses_rt = 1'b1;
                decoded.uses_rd = 1'b1;
            end
            default: ;
        endcase
    end

    // load in ID/EX feeding this decode, one bubble
    assign stall = ifid_valid && ex_is_load &&
                   ((decoded.uses_rs && rs_idx == ex_rd) ||
                    (decoded.uses_rt && rt_idx == ex_rd) ||
                    (decoded.uses_rd && rd_idx == ex_rd));

    // halt in decode shuts fetch off
    assign halt_dec      = ifid_valid && opcode == op_halt && !redirect;
    assign decoded_valid = ifid_valid && !stall && !redirect;
    assign flush_ex      = redirect;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            run        <= 1'b0;
            pc         <= reset_pc;
            ifid_valid <= 1'b0;
        end else if (redirect) begin
            // a squashed halt must not keep fetch stopped
            run        <= 1'b1;
            pc         <= redirect_pc[mem_addr_w-1:0];
            ifid_valid <= 1'b0;
        end else if (halt_dec) begin
            run        <= 1'b0;
            ifid_valid <= 1'b0;
        end else if (!stall) begin
            if (start) begin
                run <= 1'b1;
            end
            if (run) begin
                pc <= pc + mem_addr_t'(4);
            end
            ifid_valid <= run;
        end
    end

    // IF/ID word and its pc, held through a stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            ifid_instr <= instr;
            ifid_pc    <= pc;
        end
    end

endmodule

`default_nettype wire

/* rtl/execute_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_unit import tinker_pkg::*; (
    input  decoded_t   entry,
    input  wire        entry_valid,
    input  fwd_t       fwd_mem,
    input  fwd_t       fwd_wb,
    output ex_result_t result
);

    word_t rs_f;
    word_t rt_f;
    word_t rd_f;
    word_t op1;
    word_t op2;
    word_t sum;
    word_t pc_w;
    logic  writes;

    // newest producer first
    function automatic word_t forward(reg_idx_t idx, word_t reg_val,
                                      fwd_t mem_src, fwd_t wb_src);
        if (mem_src.valid && mem_src.rd == idx) begin
            return mem_src.value;
        end
        if (wb_src.valid && wb_src.rd == idx) begin
            return wb_src.value;
        end
        return reg_val;
    endfunction

    assign rs_f = forward(entry.rs, entry.rs_val, fwd_mem, fwd_wb);
    assign rt_f = forward(entry.rt, entry.rt_val, fwd_mem, fwd_wb);
    assign rd_f = forward(entry.rd, entry.rd_val, fwd_mem, fwd_wb);

    // literal forms that read rd take it as op1, so does store addressing
    assign op1  = (entry.lit_sel && entry.uses_rd) ? rd_f : rs_f;
    assign op2  = entry.lit_sel ? entry.lit : rt_f;
    assign sum  = op1 + op2;
    assign pc_w = word_t'(entry.pc);

    assign writes = entry.opcode inside {op_add, op_addi, op_sub, op_subi, op_and, op_or,
                                         op_xor, op_not, op_shr, op_shri, op_shl, op_shli,
                                         op_mov, op_movl, op_load};

    always_comb begin
        result            = '0;
        result.rd         = entry.rd;
        // load: rs+L, store: rd+L
        result.mem_addr   = sum[mem_addr_w-1:0];
        result.store_data = rs_f;
        result.target     = rd_f;
        case (entry.opcode)
            op_add, op_addi: result.alu_result = sum;
            op_sub, op_subi: result.alu_result = op1 - op2;
            op_and:          result.alu_result = op1 & op2;
            op_or:           result.alu_result = op1 | op2;
            op_xor:          result.alu_result = op1 ^ op2;
            op_not:          result.alu_result = ~op1;
            op_shr, op_shri: result.alu_result = op1 >> op2;
            op_shl, op_shli: result.alu_result = op1 << op2;
            op_mov:          result.alu_result = op1;
            // low 12 bits of rd replaced
            op_movl: result.alu_result = {op1[xlen-1:lit_w], op2[lit_w-1:0]};
            op_load:  result.is_load   = 1'b1;
            op_store: result.mem_write = 1'b1;
            op_br:    result.redirect  = 1'b1;
            op_brr: begin
                result.redirect = 1'b1;
                result.target   = pc_w + rd_f;
            end
            op_brrl: begin
                result.redirect = 1'b1;
                result.target   = pc_w + op2;
            end
            op_brnz: result.redirect = (rs_f != '0);
            op_brgt: result.redirect = ($signed(rs_f) > $signed(rt_f));
            op_halt: result.halt     = 1'b1;
            default: ;
        endcase
        // bubbles have no side effects
        result.reg_write = entry_valid && writes;
        result.mem_write = entry_valid && result.mem_write;
        result.redirect  = entry_valid && result.redirect;
        result.halt      = entry_valid && result.halt;
    end

endmodule

`default_nettype wire

/* rtl/tinker_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tinker_core import tinker_pkg::*; (
    input  wire       clk,
    input  wire       reset,
    input  wire       start,
    input  load_req_t load,
    output retire_t   retire,
    output logic      hlt
);

    decoded_t        dec;
    decoded_t        idex;
    logic            dec_valid;
    logic            idex_valid;
    logic            flush_ex;
    ex_result_t      ex_res;
    ex_result_t      exmem;
    logic            exmem_valid;
    wb_t             wb_in;
    wb_t             memwb;
    logic            memwb_valid;
    mem_addr_t       fetch_pc;
    logic [ilen-1:0] instr;
    reg_idx_t        rs_idx;
    reg_idx_t        rt_idx;
    reg_idx_t        rd_idx;
    word_t           rs_val;
    word_t           rt_val;
    word_t           rd_val;
    word_t           load_data;
    fwd_t            fwd_mem;
    fwd_t            fwd_wb;
    logic            redirect;
    logic            ex_is_load;

    assign redirect   = exmem_valid && exmem.redirect;
    assign ex_is_load = idex_valid && idex.opcode == op_load;

    // load results never forward from EX/MEM, the stall covers it
    assign fwd_mem = '{valid: exmem_valid && exmem.reg_write && !exmem.is_load,
                       rd: exmem.rd, value: exmem.alu_result};
    assign fwd_wb  = '{valid: memwb_valid && memwb.reg_write,
                       rd: memwb.rd, value: memwb.data};
    assign retire  = '{valid: fwd_wb.valid, rd: fwd_wb.rd, data: fwd_wb.value};

    // writeback data picked in MEM
    assign wb_in = '{rd: exmem.rd, reg_write: exmem.reg_write, halt: exmem.halt,
                     data: exmem.is_load ? load_data : exmem.alu_result};

    fetch_decode u_fetch_decode (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .instr         (instr),
        .rs_val        (rs_val),
        .rt_val        (rt_val),
        .rd_val        (rd_val),
        .ex_rd         (idex.rd),
        .ex_is_load    (ex_is_load),
        .redirect      (redirect),
        .redirect_pc   (exmem.target),
        .fetch_pc      (fetch_pc),
        .rs_idx        (rs_idx),
        .rt_idx        (rt_idx),
        .rd_idx        (rd_idx),
        .decoded       (dec),
        .decoded_valid (dec_valid),
        .flush_ex      (flush_ex)
    );

    register_file u_register_file (
        .clk    (clk),
        .reset  (reset),
        .rs_idx (rs_idx),
        .rt_idx (rt_idx),
        .rd_idx (rd_idx),
        .write  (fwd_wb),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .rd_val (rd_val)
    );

    // pipeline freezes once halted
    stage_reg #(.payload_t(decoded_t)) u_id_ex (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush_ex),
        .hold        (hlt),
        .in_valid    (dec_valid),
        .in_payload  (dec),
        .out_valid   (idex_valid),
        .out_payload (idex)
    );

    execute_unit u_execute_unit (
        .entry       (idex),
        .entry_valid (idex_valid),
        .fwd_mem     (fwd_mem),
        .fwd_wb      (fwd_wb),
        .result      (ex_res)
    );

    // instruction in EX is younger than a redirecting branch
    stage_reg #(.payload_t(ex_result_t)) u_ex_mem (
        .clk         (clk),
        .reset       (reset),
        .flush       (redirect),
        .hold        (hlt),
        .in_valid    (idex_valid),
        .in_payload  (ex_res),
        .out_valid   (exmem_valid),
        .out_payload (exmem)
    );

    data_memory u_data_memory (
        .clk        (clk),
        .fetch_addr (fetch_pc),
        .data_addr  (exmem.mem_addr),
        .store_en   (exmem_valid && exmem.mem_write),
        .store_data (exmem.store_data),
        .load       (load),
        .instr      (instr),
        .load_data  (load_data)
    );

    stage_reg #(.payload_t(wb_t)) u_mem_wb (
        .clk         (clk),
        .reset       (reset),
        .flush       (1'b0),
        .hold        (hlt),
        .in_valid    (exmem_valid),
        .in_payload  (wb_in),
        .out_valid   (memwb_valid),
        .out_payload (memwb)
    );

    // sticky, set by a halt in writeback
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hlt <= 1'b0;
        end else if (memwb_valid && memwb.halt) begin
            hlt <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verif/tinker_core_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module tinker_core_properties import tinker_pkg::*; (
    input wire          clk,
    input wire          reset,
    input wire retire_t retire,
    input wire          hlt
);

    // sticky until the next reset
    hlt_sticky: assert property (
        @(posedge clk) disable iff (reset) hlt |=> hlt
    ) else $error("hlt fell without a reset");

    // halted core retires nothing
    no_retire_when_halted: assert property (
        @(posedge clk) disable iff (reset) !(retire.valid && hlt)
    ) else $error("retire.valid high while hlt is set");

    // first cycle out of reset is quiet
    quiet_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> (!retire.valid && !hlt)
    ) else $error("retire or hlt active in the cycle after reset release");

endmodule

`default_nettype wire

/* verif/tinker_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module tinker_core_tb import tinker_pkg::*; ();

    localparam int    clk_period    = 40;
    localparam int    reset_cycles  = 5;
    localparam int    halt_timeout  = 2000;
    localparam int    quiet_cycles  = 10;
    localparam string testdata_path = "verif/tinker_core_testdata.hex";

    logic      clk;
    logic      reset;
    logic      start;
    load_req_t load;
    retire_t   retire;
    logic      hlt;

    // program image and expected writeback trace
    mem_addr_t       prog_addr [$];
    logic [ilen-1:0] prog_word [$];
    reg_idx_t        exp_rd [$];
    word_t           exp_data [$];
    int              retired;

    tinker_core dut (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .load   (load),
        .retire (retire),
        .hlt    (hlt)
    );

    bind tinker_core tinker_core_properties u_properties (
        .clk    (clk),
        .reset  (reset),
        .retire (retire),
        .hlt    (hlt)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic compare(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            abort_run($sformatf("** Error: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // P lines feed the load queue and W lines the trace queue
    task automatic read_testdata();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        logic [63:0] a;
        logic [63:0] b;
        fd = $fopen(testdata_path, "r");
        if (fd == 0) begin
            abort_run({"cannot open test data file ", testdata_path});
        end else begin
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%c %h %h", kind, a, b);
                if (n == 3 && kind == "P") begin
                    prog_addr.push_back(a[mem_addr_w-1:0]);
                    prog_word.push_back(b[ilen-1:0]);
                end else if (n == 3 && kind == "W") begin
                    exp_rd.push_back(a[reg_addr_w-1:0]);
                    exp_data.push_back(b);
                end
            end
            $fclose(fd);
        end
        if (prog_addr.size() == 0 || exp_rd.size() == 0) begin
            abort_run("test data file holds no program or no expected trace");
        end
    endtask

    // core must stay silent until started
    task automatic check_idle(input string phase);
        compare({phase, " retire.valid"}, '0, word_t'(retire.valid));
        compare({phase, " hlt"}, '0, word_t'(hlt));
    endtask

    // one retire against the head of the trace
    task automatic check_retire();
        if (exp_rd.size() == 0) begin
            abort_run($sformatf("extra retire of r%0d with data %h after the trace ended",
                                retire.rd, retire.data));
        end else begin
            compare($sformatf("retire %0d rd", retired), word_t'(exp_rd[0]),
                    word_t'(retire.rd));
            compare($sformatf("retire %0d data", retired), exp_data[0], retire.data);
            void'(exp_rd.pop_front());
            void'(exp_data.pop_front());
            retired++;
        end
    endtask

    initial begin
        int cycles;
        reset   = 1'b1;
        start   = 1'b0;
        load    = '0;
        retired = 0;
        read_testdata();
        for (int i = 0; i < reset_cycles; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_idle("reset");
        end
        @(posedge clk);
        reset <= 1'b0;
        // one program word per cycle through the load strobe
        for (int i = 0; i < prog_addr.size(); i++) begin
            @(posedge clk);
            load <= '{valid: 1'b1, addr: prog_addr[i], data: prog_word[i]};
            @(negedge clk);
            check_idle("program load");
        end
        @(posedge clk);
        load  <= '0;
        start <= 1'b1;
        @(negedge clk);
        check_idle("start");
        @(posedge clk);
        start <= 1'b0;
        // bounded trace compare until hlt
        cycles = 0;
        while (!hlt) begin
            @(negedge clk);
            if (retire.valid) begin
                check_retire();
            end
            cycles++;
            if (cycles > halt_timeout) begin
                abort_run($sformatf("timeout: hlt did not rise within %0d cycles", halt_timeout));
            end
        end
        // instructions past the halt stay dead
        for (int i = 0; i < quiet_cycles; i++) begin
            @(negedge clk);
            compare("after halt retire.valid", '0, word_t'(retire.valid));
            compare("after halt hlt", word_t'(1), word_t'(hlt));
        end
        if (exp_rd.size() != 0) begin
            abort_run($sformatf("hlt rose with %0d expected retires missing", exp_rd.size()));
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verif/tinker_core_testdata.hex */
# P <word address> <instruction>   program word, byte address is four times the word address
# W <rd> <value>                   expected writeback, in retire order
# alu chain, dependent back to back
P 800 C8400123
P 801 38400008
P 802 90400456
P 803 C8800007
P 804 C0C22000
P 805 D1061000
P 806 D9000009
P 807 01483000
P 808 098A2000
P 809 11CC1000
P 80A 1A0E0000
P 80B 22502000
P 80C 2A400004
P 80D 32847000
P 80E 8AD40000
# store then load of the same word, two load-use stalls
P 80F 93000100
P 810 9B120008
P 811 83580008
P 812 CB400001
P 813 83980008
P 814 C3DCE000
# jump absolute, relative by rd, relative by literal
P 815 94000200
P 816 3C000004
P 817 CC000070
P 818 44000000
P 819 CD000001
P 81A CD000001
P 81B CD000001
P 81C CC400010
P 81D 4C400000
P 81E CD000001
P 81F CD000001
P 820 CD000001
P 821 50000010
P 822 CD000001
P 823 CD000001
P 824 CD000001
# brnz not taken then taken
P 825 5C2A0000
P 826 CD800005
P 827 8CA00000
P 828 CC800044
P 829 5CAC0000
P 82A CD000001
P 82B CD000001
P 82C CD000001
# brgt with a negative operand, not taken then taken
P 82D 74082000
P 82E CDC00003
P 82F 8CE00000
P 830 CCC00064
P 831 74C44000
P 832 CD000001
P 833 CD000001
P 834 CD000001
# r20 still zero proves no shadow ran, then halt
P 835 8E280000
P 836 78000000
P 837 CE400001
P 838 CE400002
W 01 0000000000000123
W 01 0000000000012300
W 01 0000000000012456
W 02 0000000000000007
W 03 000000000001245D
W 04 0000000000000007
W 04 FFFFFFFFFFFFFFFE
W 05 000000000001245C
W 06 000000000001245F
W 07 0000000000000009
W 08 FFFFFFFFFFFFFFF6
W 09 01FFFFFFFFFFFFFF
W 09 001FFFFFFFFFFFFF
W 0A 0000000000000E00
W 0B 0000000000000E00
W 0C 0000000000000100
W 0D 001FFFFFFFFFFFFF
W 0D 0020000000000000
W 0E 001FFFFFFFFFFFFF
W 0F 003FFFFFFFFFFFFE
W 10 0000000000000200
W 10 0000000000002000
W 10 0000000000002070
W 11 0000000000000010
W 16 0000000000000005
W 12 0000000000002070
W 12 00000000000020B4
W 17 0000000000000003
W 13 0000000000002070
W 13 00000000000020D4
W 18 0000000000000000

/* tinker_core.f */
rtl/tinker_pkg.sv
rtl/stage_reg.sv
rtl/register_file.sv
rtl/data_memory.sv
rtl/fetch_decode.sv
rtl/execute_unit.sv
rtl/tinker_core.sv
verif/tinker_core_properties.sv
verif/tinker_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the tinker_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/10ps \
    --top-module tinker_core_tb \
    -f tinker_core.f \
    -o tinker_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/tinker_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
